//--- source/cacheCtrlPkg.sv
// assumes 16-bit byte addresses, 256 sets, 4-word lines and a fixed 2-cycle memory read
package cacheCtrlPkg;

   // processor data and address width
   localparam int dataWidth = 16;

   // line geometry
   localparam int wordsPerLine = 4;
   localparam int indexWidth = 8;

   // address fields
   // byte offset is bit 0, word select sits right above it
   localparam int wordLsb = 1;
   localparam int indexLsb = wordLsb + $clog2(wordsPerLine);
   localparam int tagLsb = indexLsb + indexWidth;
   // tag takes whatever is left at the top
   localparam int tagWidth = dataWidth - tagLsb;

   // memory hands back read data this many cycles after memRead
   localparam int memReadLatency = 2;

   // one data word or one byte address
   typedef logic [dataWidth-1:0] word_t;

   // tag as stored in each way
   typedef logic [tagWidth-1:0] tag_t;

   // word within a line and also the memory bank number
   typedef logic [$clog2(wordsPerLine)-1:0] wordSel_t;

   // miss controller states
   // write-back states copy the victim line out one bank per cycle
   // fill states issue four bank reads, words land two cycles later
   typedef enum logic [3:0] {
      stIdle    = 4'd0,
      // victim write-back, bank 0..3
      stWb0     = 4'd1,
      stWb1     = 4'd2,
      stWb2     = 4'd3,
      stWb3     = 4'd4,
      // line fill, reads in 0..3, cache writes in 2..5
      stFill0   = 4'd5,
      stFill1   = 4'd6,
      stFill2   = 4'd7,
      stFill3   = 4'd8,
      stFill4   = 4'd9,
      stFill5   = 4'd10,
      // replay of the original access on the refilled line
      stCacheRw = 4'd11,
      // done pulse, read data comes from the cache
      stDone    = 4'd12
   } ctrlState_t;

endpackage

//--- source/seqIf.sv
// no handshake; every field is a plain register owned by the sequencer
`timescale 1ns/1ps

interface seqIf import cacheCtrlPkg::*; ();

   // current state, straight from the state register
   ctrlState_t state;

   // way picked in idle for the whole miss
   logic reqWay;

   // miss type is only set when the request missed
   logic reqWrite;
   logic reqRead;

   // request address and write data captured in idle
   word_t reqAddr;
   word_t reqData;

   // sequencer side drives everything
   modport seq (output state, reqWay, reqWrite, reqRead, reqAddr, reqData);

   // decoder side only looks
   modport dec (input state, reqWay, reqWrite, reqRead, reqAddr, reqData);

endinterface

//--- source/waySelect.sv
// purely combinational; both hitting ways at once is not expected and way 0 wins if it happens
`timescale 1ns/1ps

module waySelect import cacheCtrlPkg::*;
(
   input  logic       hit0,
   input  logic       hit1,
   input  logic       valid0,
   input  logic       valid1,
   input  logic       dirty0,
   input  logic       dirty1,
   input  logic       victimWay,
   output logic       way,
   output logic       anyHit,
   output ctrlState_t missState
);

   // a hit only counts on a valid line
   logic hitValid0;
   logic hitValid1;
   // flags of whichever way was picked
   logic wayValid;
   logic wayDirty;

   assign hitValid0 = hit0 && valid0;
   assign hitValid1 = hit1 && valid1;
   assign anyHit = hitValid0 || hitValid1;

   // hit way first, then an empty way, then the replacement policy
   always_comb
   begin
      if (hitValid0) way = 1'b0;
      else if (hitValid1) way = 1'b1;
      else if (!valid0) way = 1'b0;
      else if (!valid1) way = 1'b1;
      else way = victimWay;
   end

   assign wayValid = way ? valid1 : valid0;
   assign wayDirty = way ? dirty1 : dirty0;

   // dirty victim must go back to memory before the fill
   assign missState = (wayValid && wayDirty) ? stWb0 : stFill0;

endmodule

//--- source/missSequencer.sv
// once a miss starts the sequence runs to stDone; the request must stay put while busyOut is high
`timescale 1ns/1ps

module missSequencer import cacheCtrlPkg::*;
(
   input  logic       clk,
   input  logic       rstN,
   input  logic       rd,
   input  logic       wr,
   input  word_t      addr,
   input  word_t      dataIn,
   input  logic       stall,
   input  logic       way,
   input  logic       anyHit,
   input  ctrlState_t missState,
   output logic       busyOut,
   seqIf.seq          sq
);

   // exactly one of rd and wr, not stalled, not in reset
   logic reqValid;
   // valid request that found no usable line
   logic missStart;
   ctrlState_t nextState;

   assign reqValid = (rd ^ wr) && !stall && rstN;
   assign missStart = reqValid && !anyHit;

   // anything but idle keeps the processor waiting
   assign busyOut = (sq.state != stIdle);

   always_comb
   begin
      nextState = sq.state;
      case (sq.state)
         stIdle:
         begin
            // hits finish in idle, misses branch on the victim state
            if (missStart) nextState = missState;
         end
         // write-back walks banks 0..3
         stWb0: nextState = stWb1;
         stWb1: nextState = stWb2;
         stWb2: nextState = stWb3;
         stWb3: nextState = stFill0;
         // fill always takes six cycles
         stFill0: nextState = stFill1;
         stFill1: nextState = stFill2;
         stFill2: nextState = stFill3;
         stFill3: nextState = stFill4;
         stFill4: nextState = stFill5;
         stFill5: nextState = stCacheRw;
         stCacheRw: nextState = stDone;
         stDone: nextState = stIdle;
         default: nextState = stIdle;
      endcase
   end

   // state register
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         sq.state <= stIdle;
      end
      else
      begin
         sq.state <= nextState;
      end
   end

   // control latches
   // follow the inputs every idle cycle, frozen for the rest of the miss
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         sq.reqWay <= 1'b0;
         sq.reqRead <= 1'b0;
         sq.reqWrite <= 1'b0;
      end
      else if (sq.state == stIdle)
      begin
         sq.reqWay <= way;
         // only a miss leaves a pending access for stCacheRw/stDone
         sq.reqRead <= missStart && rd;
         sq.reqWrite <= missStart && wr;
      end
   end

   // payload latches use the same capture window
   always_ff @(posedge clk)
   begin
      if (sq.state == stIdle)
      begin
         sq.reqAddr <= addr;
         sq.reqData <= dataIn;
      end
   end

endmodule

//--- source/portDecoder.sv
// Mealy decode; idle outputs follow the live request, miss states use only the latched request
`timescale 1ns/1ps

module portDecoder import cacheCtrlPkg::*;
(
   input  logic     rd,
   input  logic     wr,
   input  word_t    addr,
   input  word_t    dataIn,
   input  logic     stall,
   input  logic     rstN,
   input  logic     anyHit,
   input  logic     hit0,
   input  logic     hit1,
   input  logic     valid0,
   input  logic     valid1,
   input  tag_t     tag0,
   input  tag_t     tag1,
   input  word_t    cacheDataOut,
   input  word_t    memDataOut,
   seqIf.dec        sq,
   output word_t    dataOut,
   output word_t    addrOut,
   output wordSel_t wordOut,
   output logic     done,
   output logic     cacheWrite0,
   output logic     cacheWrite1,
   output logic     comp0,
   output logic     comp1,
   output logic     en0,
   output logic     en1,
   output logic     memWrite,
   output logic     memRead
);

   logic reqValid;
   logic wrReq;
   logic hitValid0;
   logic hitValid1;
   // fields of the latched address
   logic [indexWidth-1:0] reqIndex;
   wordSel_t reqWord;
   // tag of the line being evicted
   tag_t victimTag;
   // bank being written back / read / landed
   wordSel_t wbBank;
   wordSel_t fillBank;
   wordSel_t fillWord;
   // fill states that issue a read, and those where read data arrives
   logic fillIssue;
   logic fillLand;

   assign reqValid = (rd ^ wr) && !stall && rstN;
   assign wrReq = reqValid && wr;
   assign hitValid0 = hit0 && valid0;
   // way 0 takes priority, same as the way choice
   assign hitValid1 = hit1 && valid1 && !hitValid0;

   assign reqIndex = sq.reqAddr[tagLsb-1:indexLsb];
   assign reqWord = sq.reqAddr[indexLsb-1:wordLsb];
   assign victimTag = sq.reqWay ? tag1 : tag0;

   // bank numbers fall out of the state encoding
   assign wbBank = wordSel_t'(sq.state - stWb0);
   assign fillBank = wordSel_t'(sq.state - stFill0);
   // data for bank k shows up memReadLatency states after its read
   assign fillWord = wordSel_t'(sq.state - stFill0 - memReadLatency);
   assign fillIssue = sq.state inside {[stFill0:stFill3]};
   assign fillLand = sq.state inside {[stFill2:stFill5]};

   always_comb
   begin
      // quiet outputs and the latched address unless a state says otherwise
      dataOut = '0;
      addrOut = sq.reqAddr;
      wordOut = reqWord;
      done = 1'b0;
      cacheWrite0 = 1'b0;
      cacheWrite1 = 1'b0;
      comp0 = 1'b0;
      comp1 = 1'b0;
      en0 = 1'b0;
      en1 = 1'b0;
      memWrite = 1'b0;
      memRead = 1'b0;
      case (sq.state)
         stIdle:
         begin
            // compare on both ways, hit completes right here
            addrOut = addr;
            wordOut = addr[indexLsb-1:wordLsb];
            dataOut = wrReq ? dataIn : '0;
            comp0 = reqValid;
            comp1 = reqValid;
            en0 = reqValid;
            en1 = reqValid;
            done = reqValid && anyHit;
            cacheWrite0 = wrReq && hitValid0;
            cacheWrite1 = wrReq && hitValid1;
         end
         stWb0, stWb1, stWb2, stWb3:
         begin
            // read victim word k from the cache and store it to bank k
            memWrite = 1'b1;
            addrOut = {victimTag, reqIndex, wbBank, 1'b0};
            wordOut = wbBank;
            dataOut = cacheDataOut;
            en0 = !sq.reqWay;
            en1 = sq.reqWay;
         end
         stFill0, stFill1, stFill2, stFill3, stFill4, stFill5:
         begin
            en0 = !sq.reqWay;
            en1 = sq.reqWay;
            // read and land phases overlap in stFill2/stFill3
            if (fillIssue)
            begin
               memRead = 1'b1;
               addrOut = {sq.reqAddr[dataWidth-1:tagLsb], reqIndex, fillBank, 1'b0};
            end
            // comp stays low so the write also sets tag and valid
            if (fillLand)
            begin
               cacheWrite0 = !sq.reqWay;
               cacheWrite1 = sq.reqWay;
               wordOut = fillWord;
               dataOut = memDataOut;
            end
         end
         stCacheRw:
         begin
            // replay the access as a hit on the chosen way
            comp0 = !sq.reqWay;
            comp1 = sq.reqWay;
            en0 = !sq.reqWay;
            en1 = sq.reqWay;
            cacheWrite0 = sq.reqWrite && !sq.reqWay;
            cacheWrite1 = sq.reqWrite && sq.reqWay;
            dataOut = sq.reqWrite ? sq.reqData : '0;
         end
         stDone:
         begin
            done = 1'b1;
            // keep the way enabled so read data is still on cacheDataOut
            en0 = sq.reqRead && !sq.reqWay;
            en1 = sq.reqRead && sq.reqWay;
         end
         default:
         begin
            // unreachable encodings also drop the address
            addrOut = '0;
         end
      endcase
   end

endmodule

//--- source/cacheCtrlTop.sv
// miss controller only; cache arrays, memory banks and the replacement policy live outside
`timescale 1ns/1ps

module cacheCtrlTop import cacheCtrlPkg::*;
(
   input  logic     clk,
   input  logic     rstN,
   // processor request
   input  logic     rd,
   input  logic     wr,
   input  word_t    addr,
   input  word_t    dataIn,
   input  logic     stall,
   // cache way status
   input  logic     hit0,
   input  logic     hit1,
   input  logic     valid0,
   input  logic     valid1,
   input  logic     dirty0,
   input  logic     dirty1,
   input  tag_t     tag0,
   input  tag_t     tag1,
   input  word_t    cacheDataOut,
   // replacement policy pick when both ways are full
   input  logic     victimWay,
   // memory read data
   input  word_t    memDataOut,
   // cache and memory controls
   output word_t    dataOut,
   output word_t    addrOut,
   output wordSel_t wordOut,
   output logic     done,
   output logic     cacheWrite0,
   output logic     cacheWrite1,
   output logic     comp0,
   output logic     comp1,
   output logic     en0,
   output logic     en1,
   output logic     memWrite,
   output logic     memRead,
   output logic     busyOut
);

   // way choice results
   logic way;
   logic anyHit;
   ctrlState_t missState;

   // sequencer to decoder
   seqIf seqBus ();

   waySelect i_waySelect (
      .hit0      (hit0),
      .hit1      (hit1),
      .valid0    (valid0),
      .valid1    (valid1),
      .dirty0    (dirty0),
      .dirty1    (dirty1),
      .victimWay (victimWay),
      .way       (way),
      .anyHit    (anyHit),
      .missState (missState)
   );

   missSequencer i_missSequencer (
      .clk       (clk),
      .rstN      (rstN),
      .rd        (rd),
      .wr        (wr),
      .addr      (addr),
      .dataIn    (dataIn),
      .stall     (stall),
      .way       (way),
      .anyHit    (anyHit),
      .missState (missState),
      .busyOut   (busyOut),
      .sq        (seqBus.seq)
   );

   portDecoder i_portDecoder (
      .rd           (rd),
      .wr           (wr),
      .addr         (addr),
      .dataIn       (dataIn),
      .stall        (stall),
      .rstN         (rstN),
      .anyHit       (anyHit),
      .hit0         (hit0),
      .hit1         (hit1),
      .valid0       (valid0),
      .valid1       (valid1),
      .tag0         (tag0),
      .tag1         (tag1),
      .cacheDataOut (cacheDataOut),
      .memDataOut   (memDataOut),
      .sq           (seqBus.dec),
      .dataOut      (dataOut),
      .addrOut      (addrOut),
      .wordOut      (wordOut),
      .done         (done),
      .cacheWrite0  (cacheWrite0),
      .cacheWrite1  (cacheWrite1),
      .comp0        (comp0),
      .comp1        (comp1),
      .en0          (en0),
      .en1          (en1),
      .memWrite     (memWrite),
      .memRead      (memRead)
   );

endmodule

//--- verif/tbCacheCtrl.sv
// fixed-seed LFSR stimulus; way flags held until done; memory data lands 2 cycles after memRead
`timescale 1ns/1ps

module tbCacheCtrl
   import cacheCtrlPkg::*;
();

   localparam int numRequests = 200;
   // a dirty miss takes 13 cycles counting the request cycle
   localparam int timeoutCycles = 14 * numRequests + 50;

   logic clk;
   logic rstN;
   // processor side
   logic rd;
   logic wr;
   word_t addr;
   word_t dataIn;
   logic stall;
   // cache way status
   logic hit0;
   logic hit1;
   logic valid0;
   logic valid1;
   logic dirty0;
   logic dirty1;
   tag_t tag0;
   tag_t tag1;
   word_t cacheDataOut;
   logic victimWay;
   word_t memDataOut;
   // DUT outputs
   word_t dataOut;
   word_t addrOut;
   wordSel_t wordOut;
   logic done;
   logic cacheWrite0;
   logic cacheWrite1;
   logic comp0;
   logic comp1;
   logic en0;
   logic en1;
   logic memWrite;
   logic memRead;
   logic busyOut;

   // four memory banks indexed by line address
   word_t memBank [4][8192];
   // two-stage read pipeline
   word_t rdPipe0;
   word_t rdPipe1;
   logic [31:0] lfsrState = 32'hf28e50c5;
   int cycleCount = 0;
   int errorCount = 0;
   int checkCount = 0;
   int reqNum = 0;

   cacheCtrlTop i_cacheCtrlTop (.*);

   // fixed cache contents per way and word with the way taken from en1
   function automatic word_t cacheWord(input logic w, input wordSel_t k);
      cacheWord = w ? {14'h2c4d, k} : {14'h1b72, k};
   endfunction

   assign cacheDataOut = cacheWord(en1, wordOut);

   always #4 clk = ~clk;

   // run limit
   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleCount > timeoutCycles)
      begin
         $display("timeout after %0d cycles, the DUT never finished request %0d",
                  cycleCount, reqNum);
         $display("Verification failed");
         $finish;
      end
   end

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      lfsrNext = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one LFSR step per bit
   task automatic randBits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsrState = lfsrNext(lfsrState);
         v = {v[30:0], lfsrState[0]};
      end
   endtask

   // initial memory contents depend on every address bit
   function automatic word_t memFill(input word_t a);
      memFill = {a[10:0], a[15:11]} ^ {8'h00, a[15:8]} ^ 16'h5ac3;
   endfunction

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("[FAIL] request %0d %s: got 0x%0h, expected 0x%0h", reqNum, name, actual,
                  expected);
      end
   endtask

   // memory side of the bus samples mid-cycle
   task automatic memoryModel();
      if (memWrite)
         memBank[addrOut[2:1]][addrOut[15:3]] = dataOut;
      rdPipe0 = memRead ? memBank[addrOut[2:1]][addrOut[15:3]] : 16'h0000;
   endtask

   task automatic advanceCycle();
      memoryModel();
      @(posedge clk);
      #1;
      // read data moves one stage per cycle
      memDataOut = rdPipe1;
      rdPipe1 = rdPipe0;
   endtask

   task automatic drawRequest();
      logic [31:0] r;
      randBits(1, r);
      wr = r[0];
      rd = !r[0];
      randBits(16, r);
      addr = r[15:0];
      randBits(16, r);
      dataIn = r[15:0];
      // about one request in eight is stalled
      randBits(3, r);
      stall = (r[2:0] == 3'd0);
      randBits(7, r);
      {hit0, hit1, valid0, valid1, dirty0, dirty1, victimWay} = r[6:0];
      randBits(10, r);
      tag0 = r[4:0];
      tag1 = r[9:5];
   endtask

   task automatic runRequest();
      logic hv0;
      logic hv1;
      logic isHit;
      logic expWay;
      logic expDirty;
      int latency;
      int fillStart;
      int c;
      wordSel_t k;
      drawRequest();
      hv0 = hit0 && valid0;
      hv1 = hit1 && valid1;
      isHit = hv0 || hv1;
      // hitting way, then an empty way, then the replacement pick
      if (hv0) expWay = 1'b0;
      else if (hv1) expWay = 1'b1;
      else if (!valid0) expWay = 1'b0;
      else if (!valid1) expWay = 1'b1;
      else expWay = victimWay;
      expDirty = expWay ? (valid1 && dirty1) : (valid0 && dirty0);
      @(negedge clk);
      checkValue("busyOut", 32'(busyOut), 32'(1'b0));
      if (stall)
      begin
         // stalled request must not start anything
         checkValue("done", 32'(done), 32'(1'b0));
         checkValue("en0", 32'(en0), 32'(1'b0));
         checkValue("en1", 32'(en1), 32'(1'b0));
         advanceCycle();
         return;
      end
      checkValue("done", 32'(done), 32'(isHit));
      checkValue("en0", 32'(en0), 32'(1'b1));
      checkValue("en1", 32'(en1), 32'(1'b1));
      checkValue("cacheWrite0", 32'(cacheWrite0), 32'(wr && isHit && !expWay));
      checkValue("cacheWrite1", 32'(cacheWrite1), 32'(wr && isHit && expWay));
      if (wr && isHit)
         checkValue("dataOut", 32'(dataOut), 32'(dataIn));
      if (isHit)
      begin
         advanceCycle();
         return;
      end
      latency = expDirty ? 12 : 8;
      fillStart = expDirty ? 5 : 1;
      c = 0;
      do
      begin
         advanceCycle();
         c++;
         @(negedge clk);
         checkValue("busyOut", 32'(busyOut), 32'(1'b1));
         // write-back of the victim takes one bank per cycle
         if (expDirty && c <= 4)
         begin
            k = wordSel_t'(c - 1);
            checkValue("memWrite", 32'(memWrite), 32'(1'b1));
            checkValue("addrOut", 32'(addrOut),
                       32'({expWay ? tag1 : tag0, addr[10:3], k, 1'b0}));
            checkValue("wordOut", 32'(wordOut), 32'(k));
            checkValue("dataOut", 32'(dataOut), 32'(cacheWord(expWay, k)));
         end
         // bank reads of the requested line
         if (c >= fillStart && c < fillStart + 4)
         begin
            k = wordSel_t'(c - fillStart);
            checkValue("memRead", 32'(memRead), 32'(1'b1));
            checkValue("addrOut", 32'(addrOut), 32'({addr[15:3], k, 1'b0}));
         end
         // read data lands two cycles later
         if (c >= fillStart + 2 && c < fillStart + 6)
         begin
            k = wordSel_t'(c - fillStart - 2);
            checkValue("cacheWrite0", 32'(cacheWrite0), 32'(!expWay));
            checkValue("cacheWrite1", 32'(cacheWrite1), 32'(expWay));
            checkValue(expWay ? "comp1" : "comp0", 32'(expWay ? comp1 : comp0), 32'(1'b0));
            checkValue("wordOut", 32'(wordOut), 32'(k));
            checkValue("dataOut", 32'(dataOut), 32'(memBank[k][addr[15:3]]));
         end
         // replayed access on the refilled line
         if (c == latency - 1)
         begin
            checkValue("comp0", 32'(comp0), 32'(!expWay));
            checkValue("comp1", 32'(comp1), 32'(expWay));
            checkValue("cacheWrite0", 32'(cacheWrite0), 32'(wr && !expWay));
            checkValue("cacheWrite1", 32'(cacheWrite1), 32'(wr && expWay));
            if (wr)
            begin
               checkValue("dataOut", 32'(dataOut), 32'(dataIn));
               checkValue("wordOut", 32'(wordOut), 32'(addr[2:1]));
            end
         end
      end
      while (done !== 1'b1);
      checkValue("done latency", 32'(c), 32'(latency));
      // a read miss keeps its way enabled while done is high
      checkValue("en0", 32'(en0), 32'(rd && !expWay));
      checkValue("en1", 32'(en1), 32'(rd && expWay));
      advanceCycle();
   endtask

   initial
   begin
      clk = 1'b0;
      rstN = 1'b0;
      {rd, wr, stall, hit0, hit1, valid0, valid1, dirty0, dirty1, victimWay} = '0;
      addr = '0;
      dataIn = '0;
      tag0 = '0;
      tag1 = '0;
      memDataOut = '0;
      rdPipe0 = '0;
      rdPipe1 = '0;
      for (int b = 0; b < 4; b++)
      begin
         for (int l = 0; l < 8192; l++)
            memBank[b][l] = memFill({l[12:0], b[1:0], 1'b0});
      end
      // requests during reset are ignored
      repeat (3)
      begin
         @(posedge clk);
         #1;
         drawRequest();
         @(negedge clk);
         checkValue("done", 32'(done), 32'(1'b0));
         checkValue("busyOut", 32'(busyOut), 32'(1'b0));
         checkValue("memRead", 32'(memRead), 32'(1'b0));
         checkValue("memWrite", 32'(memWrite), 32'(1'b0));
      end
      @(posedge clk);
      #1;
      rstN = 1'b1;
      for (int n = 0; n < numRequests; n++)
      begin
         reqNum = n;
         runRequest();
      end
      $display("checks %0d, errors %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

//--- list.f
source/cacheCtrlPkg.sv
source/seqIf.sv
source/waySelect.sv
source/missSequencer.sv
source/portDecoder.sv
source/cacheCtrlTop.sv
verif/tbCacheCtrl.sv

//--- Makefile
TOOL       := verilator
TOP        := tbCacheCtrl
FILELIST   := list.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --Mdir $(BUILD_DIR)
PASS_TEXT  := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
